// ==== Bender.yml ====
package:
  name: ps2_mouse_xy

sources:
  - include_dirs:
      - common
    files:
      - common/cursor_pkg.sv
      - common/ps2_proto_pkg.sv
      - common/ps2_frame_if.sv
      - ps2_link/ps2_edge_filter.sv
      - ps2_link/ps2_frame_gather.sv
      - ps2_link/ps2_link_ctrl.sv
      - hw/cursor_tracker.sv
      - hw/ps2_mouse_xy.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/ps2_checker.sv
      - tb/tb_ps2_mouse_xy.sv

// ==== common/cursor_pkg.sv ====
// ---------------------------------------------------------------------
// cursor side types, coordinates and the button field
// ---------------------------------------------------------------------
`include "ps2_mouse_macros.svh"

package cursor_pkg;

  // absolute screen coordinate, always between 0 and the screen limit
  typedef logic [`CURSOR_BITS-1:0] coord_t;

  // button field ordered left-middle-right from the MSB down
  typedef logic [2:0] buttons_t;

  // bit positions inside buttons_t
  localparam int btn_left   = 2;
  localparam int btn_middle = 1;
  localparam int btn_right  = 0;

endpackage

// ==== common/ps2_frame_if.sv ====
// ---------------------------------------------------------------------
// gather status and decoded report shared by the frame gatherer, the
// link control and the cursor tracker
// ---------------------------------------------------------------------
`timescale 1ns/10ps

interface ps2_frame_if;

  ps2_proto_pkg::bit_count_t   bit_count;
  logic                        watchdog_done;
  logic                        packet_good;
  ps2_proto_pkg::move_report_t report;

  // the gatherer owns every signal here
  modport gather (output bit_count, output watchdog_done, output packet_good,
                  output report);

  // the sequencer only needs the counters and the verdict
  modport ctrl (input bit_count, input watchdog_done, input packet_good);

  // the tracker reads the report when the sequencer strobes it
  modport track (input report);

endinterface

// ==== common/ps2_mouse_macros.svh ====
// ---------------------------------------------------------------------
// default sizes and timer counts for the PS/2 mouse front end
// included wherever a width, a packet length or a screen limit is needed
// ---------------------------------------------------------------------
`ifndef PS2_MOUSE_MACROS_SVH
`define PS2_MOUSE_MACROS_SVH

// one movement packet is three 11-bit frames
`define PS2_PACKET_BITS 33
`define PS2_FRAME_BITS 11

// idle clock cycles that close a packet, must exceed the inter-byte gap
`define PS2_WATCHDOG_CYCLES 26000
`define PS2_WATCHDOG_BITS 15

// hold time after each PS/2 clock edge before the next edge is accepted
`define PS2_DEBOUNCE_CYCLES 246
`define PS2_DEBOUNCE_BITS 8

// cursor coordinate width and the default 640x480 screen limits
`define CURSOR_BITS 12
`define CURSOR_MAX_X 639
`define CURSOR_MAX_Y 479

`endif

// ==== common/ps2_proto_pkg.sv ====
// ---------------------------------------------------------------------
// PS/2 wire protocol types: one frame, the three-frame packet and the
// decoded movement report that the cursor side consumes
// ---------------------------------------------------------------------
`include "ps2_mouse_macros.svh"

package ps2_proto_pkg;

  // number of byte frames in one movement packet
  localparam int ps2_frames = `PS2_PACKET_BITS / `PS2_FRAME_BITS;

  // stream-enable command, the mouse answers with an FA acknowledge byte
  localparam logic [7:0] PS2_CMD_ENABLE_STREAM = 8'hf4;

  // one frame as it arrives, start bit first, so start sits at bit 0
  typedef struct packed {
    logic       stop;
    logic       parity;
    logic [7:0] data;
    logic       start;
  } ps2_frame_t;

  // the shift register fills LSB first, so byte 0 lands in frames[0]
  typedef union packed {
    logic [`PS2_PACKET_BITS-1:0]  raw;
    ps2_frame_t [ps2_frames-1:0]  frames;
  } ps2_packet_u;

  // increments are two's complement with the sign taken from byte 0
  typedef struct packed {
    logic signed [8:0]    dx;
    logic signed [8:0]    dy;
    cursor_pkg::buttons_t buttons;
  } move_report_t;

  // wide enough to count a full packet plus a few stray bits
  typedef logic [$clog2(`PS2_PACKET_BITS + 1)-1:0] bit_count_t;

endpackage

// ==== files.f ====
+incdir+common
common/cursor_pkg.sv
common/ps2_proto_pkg.sv
common/ps2_frame_if.sv
ps2_link/ps2_edge_filter.sv
ps2_link/ps2_frame_gather.sv
ps2_link/ps2_link_ctrl.sv
hw/cursor_tracker.sv
hw/ps2_mouse_xy.sv
tb/ps2_checker.sv
tb/tb_ps2_mouse_xy.sv

// ==== hw/cursor_tracker.sv ====
// ---------------------------------------------------------------------
// absolute cursor position, adds each accepted report to x and y with
// clamping to the screen and latches the buttons
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "ps2_mouse_macros.svh"

module cursor_tracker #(
  parameter int max_x = `CURSOR_MAX_X,
  parameter int max_y = `CURSOR_MAX_Y
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 report_strobe,
  ps2_frame_if.track           frame,
  output cursor_pkg::coord_t   mx,
  output cursor_pkg::coord_t   my,
  output cursor_pkg::buttons_t btn_click
);

  // two extra bits hold the sign and the carry past the coordinate range
  localparam int sum_bits = `CURSOR_BITS + 2;

  logic signed [sum_bits-1:0] x_sum;
  logic signed [sum_bits-1:0] y_sum;

  // saturates a signed sum into 0 .. limit
  function automatic cursor_pkg::coord_t clamp_coord(
    input logic signed [sum_bits-1:0] value,
    input int                         limit
  );
    cursor_pkg::coord_t result;
    if (value < 0)
      result = '0;
    else if (value > limit)
      result = cursor_pkg::coord_t'(limit);
    else
      result = cursor_pkg::coord_t'(value);
    return result;
  endfunction

  // mouse y grows upward while screen rows grow downward, hence the minus
  assign x_sum = $signed({2'b00, mx}) + $signed(frame.report.dx);
  assign y_sum = $signed({2'b00, my}) - $signed(frame.report.dy);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mx        <= '0;
      my        <= '0;
      btn_click <= '0;
    end
    else if (report_strobe)
    begin
      mx        <= clamp_coord(x_sum, max_x);
      my        <= clamp_coord(y_sum, max_y);
      btn_click <= frame.report.buttons;
    end
  end

endmodule

// ==== hw/ps2_mouse_xy.sv ====
// ---------------------------------------------------------------------
// PS/2 mouse front end, open-drain clock and data pins in and the
// absolute cursor position, buttons and acknowledge error out
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "ps2_mouse_macros.svh"

module ps2_mouse_xy #(
  parameter int watchdog_cycles = `PS2_WATCHDOG_CYCLES,
  parameter int debounce_cycles = `PS2_DEBOUNCE_CYCLES,
  parameter int max_x           = `CURSOR_MAX_X,
  parameter int max_y           = `CURSOR_MAX_Y
) (
  input  logic                 clk,
  input  logic                 reset,
  inout  wire                  ps2_clk,
  inout  wire                  ps2_data,
  output cursor_pkg::coord_t   mx,
  output cursor_pkg::coord_t   my,
  output cursor_pkg::buttons_t btn_click,
  output logic                 error_no_ack
);

  logic       clean_clk;
  logic       rise;
  logic       fall;
  logic       report_strobe;
  logic       clk_drive_low;
  logic       data_drive_low;
  logic [1:0] data_sync;
  logic       ps2_data_in;

  ps2_frame_if frame_bus ();

  // both lines need a pull-up, the host only ever pulls low or lets go
  assign ps2_clk  = clk_drive_low ? 1'b0 : 1'bz;
  assign ps2_data = data_drive_low ? 1'b0 : 1'bz;

  // data is only sampled on fall strobes, which lag the pin by three cycles
  always_ff @(posedge clk)
  begin
    if (reset)
      data_sync <= 2'b11;
    else
      data_sync <= {data_sync[0], ps2_data};
  end

  assign ps2_data_in = data_sync[1];

  ps2_edge_filter #(.debounce_cycles(debounce_cycles)) filter_i (
    .clk, .reset, .ps2_clk_in(ps2_clk), .clean_clk, .rise, .fall
  );

  ps2_frame_gather #(.watchdog_cycles(watchdog_cycles)) gather_i (
    .clk, .reset, .ps2_data_in, .rise, .fall, .frame(frame_bus.gather)
  );

  ps2_link_ctrl ctrl_i (
    .clk, .reset, .clean_clk, .rise, .fall, .ps2_data_in,
    .frame(frame_bus.ctrl), .report_strobe, .clk_drive_low, .data_drive_low,
    .error_no_ack
  );

  cursor_tracker #(.max_x(max_x), .max_y(max_y)) tracker_i (
    .clk, .reset, .report_strobe, .frame(frame_bus.track), .mx, .my, .btn_click
  );

endmodule

// ==== ps2_link/ps2_edge_filter.sv ====
// ---------------------------------------------------------------------
// debounced follower for the PS/2 clock line, gives a clean level and
// single-cycle rise and fall strobes to the rest of the link
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "ps2_mouse_macros.svh"

module ps2_edge_filter #(
  parameter int debounce_cycles = `PS2_DEBOUNCE_CYCLES
) (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk_in,
  output logic clean_clk,
  output logic rise,
  output logic fall
);

  typedef enum logic [2:0] {
    st_clk_high,
    st_fall_edge,
    st_fall_wait,
    st_clk_low,
    st_rise_edge,
    st_rise_wait
  } filt_state_t;

  filt_state_t state;
  filt_state_t next_state;

  // two flops take the slow open-drain line into the clk domain
  logic [1:0] sync_q;
  logic [`PS2_DEBOUNCE_BITS-1:0] debounce_count;
  logic debounce_done;
  logic line;

  always_ff @(posedge clk)
  begin
    // the bus idles high through its pull-up
    if (reset)
      sync_q <= 2'b11;
    else
      sync_q <= {sync_q[0], ps2_clk_in};
  end

  assign line = sync_q[1];

  // ---------------------------------------------------------------------
  // debounce timer, restarted by each strobe and held once it expires
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || rise || fall)
      debounce_count <= '0;
    else if (!debounce_done)
      debounce_count <= debounce_count + 1'b1;
  end

  assign debounce_done = (debounce_count == `PS2_DEBOUNCE_BITS'(debounce_cycles - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_clk_high;
    else
      state <= next_state;
  end

  // the edge states last one cycle, the wait states ignore the line until
  // the debounce time has passed
  always_comb
  begin
    next_state = state;
    case (state)
      st_clk_high:  if (!line) next_state = st_fall_edge;
      st_fall_edge: next_state = st_fall_wait;
      st_fall_wait: if (debounce_done) next_state = st_clk_low;
      st_clk_low:   if (line) next_state = st_rise_edge;
      st_rise_edge: next_state = st_rise_wait;
      st_rise_wait: if (debounce_done) next_state = st_clk_high;
      default:      next_state = st_clk_high;
    endcase
  end

  // strobes come three cycles after the pin moves, two sync plus one state
  assign fall      = (state == st_fall_edge);
  assign rise      = (state == st_rise_edge);
  assign clean_clk = (state == st_clk_high) || (state == st_rise_edge) ||
                     (state == st_rise_wait);

endmodule

// ==== ps2_link/ps2_frame_gather.sv ====
// ---------------------------------------------------------------------
// receive path of the PS/2 link: shifts data bits on each clock fall,
// counts them, times the idle gap and checks and decodes the packet
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "ps2_mouse_macros.svh"

module ps2_frame_gather #(
  parameter int watchdog_cycles = `PS2_WATCHDOG_CYCLES
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        ps2_data_in,
  input  logic        rise,
  input  logic        fall,
  ps2_frame_if.gather frame
);

  ps2_proto_pkg::ps2_packet_u   packet;
  ps2_proto_pkg::bit_count_t    bit_count;
  ps2_proto_pkg::move_report_t  report;
  logic [`PS2_WATCHDOG_BITS-1:0] watchdog_count;
  logic watchdog_done;
  logic good;

  // the newest bit enters at the top, so after 33 falls byte 0 sits lowest
  always_ff @(posedge clk)
  begin
    if (fall)
      packet.raw <= {ps2_data_in, packet.raw[`PS2_PACKET_BITS-1:1]};
  end

  // a quiet line clears a partial count so one glitch cannot shift
  // every later packet out of alignment
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (fall)
      bit_count <= bit_count + 1'b1;
    else if (watchdog_done)
      bit_count <= '0;
  end

  // ---------------------------------------------------------------------
  // watchdog, counts idle cycles since the last edge of either kind
  // ---------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || rise || fall)
      watchdog_count <= '0;
    else if (!watchdog_done)
      watchdog_count <= watchdog_count + 1'b1;
  end

  // stays high from the last count until the next strobe
  assign watchdog_done = (watchdog_count == `PS2_WATCHDOG_BITS'(watchdog_cycles - 1));

  // every frame needs a low start, a high stop and odd parity over data
  // plus the parity bit
  always_comb
  begin
    good = 1'b1;
    for (int i = 0; i < ps2_proto_pkg::ps2_frames; i++)
    begin
      if (packet.frames[i].start != 1'b0)
        good = 1'b0;
      if (packet.frames[i].stop != 1'b1)
        good = 1'b0;
      if (packet.frames[i].parity != ~^packet.frames[i].data)
        good = 1'b0;
    end
  end

  // byte 0 carries the sign bits and buttons, bytes 1 and 2 the magnitudes
  // byte 0 layout is YV XV YS XS 1 M R L, overflow bits are not used
  always_comb
  begin
    report.dx = {packet.frames[0].data[4], packet.frames[1].data};
    report.dy = {packet.frames[0].data[5], packet.frames[2].data};
    report.buttons[cursor_pkg::btn_left]   = packet.frames[0].data[0];
    report.buttons[cursor_pkg::btn_middle] = packet.frames[0].data[2];
    report.buttons[cursor_pkg::btn_right]  = packet.frames[0].data[1];
  end

  assign frame.bit_count     = bit_count;
  assign frame.watchdog_done = watchdog_done;
  assign frame.packet_good   = good;
  assign frame.report        = report;

endmodule

// ==== ps2_link/ps2_link_ctrl.sv ====
// ---------------------------------------------------------------------
// link sequencer: enables streaming on the mouse, checks its acknowledge,
// then accepts or drops each gathered packet
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "ps2_mouse_macros.svh"

module ps2_link_ctrl (
  input  logic      clk,
  input  logic      reset,
  input  logic      clean_clk,
  input  logic      rise,
  input  logic      fall,
  input  logic      ps2_data_in,
  ps2_frame_if.ctrl frame,
  output logic      report_strobe,
  output logic      clk_drive_low,
  output logic      data_drive_low,
  output logic      error_no_ack
);

  typedef enum logic [3:0] {
    st_reset,
    st_hold_clk,
    st_send,
    st_ack,
    st_await_reply,
    st_wait,
    st_gather,
    st_verify,
    st_error
  } link_state_t;

  // command frame as it goes on the wire, parity makes the ones count odd
  localparam ps2_proto_pkg::ps2_frame_t cmd_frame = '{
    stop:   1'b1,
    parity: ~^ps2_proto_pkg::PS2_CMD_ENABLE_STREAM,
    data:   ps2_proto_pkg::PS2_CMD_ENABLE_STREAM,
    start:  1'b0
  };

  // the device clocks out ten bits, d0 through stop, before it acknowledges
  localparam ps2_proto_pkg::bit_count_t last_tx_count =
    ps2_proto_pkg::bit_count_t'(`PS2_FRAME_BITS - 1);
  // acknowledge frame plus the FA reply byte
  localparam ps2_proto_pkg::bit_count_t reply_count =
    ps2_proto_pkg::bit_count_t'(2 * `PS2_FRAME_BITS);
  localparam ps2_proto_pkg::bit_count_t packet_count =
    ps2_proto_pkg::bit_count_t'(`PS2_PACKET_BITS);

  link_state_t state;
  link_state_t next_state;
  logic        tx_bit;
  logic [3:0]  tx_index;
  logic        tx_next;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_reset;
    else
      state <= next_state;
  end

  // ---------------------------------------------------------------------
  // command transmit
  // ---------------------------------------------------------------------
  // data low at the clock release is the start bit
  // after the rise that follows fall n the host presents frame bit n+1,
  // so d0 is set up by the release rise and the device samples each bit
  // on its own rising edge, stop is a released line
  assign tx_index = frame.bit_count[3:0] + 4'd1;
  assign tx_next  = (tx_index < 4'(`PS2_FRAME_BITS)) ? cmd_frame[tx_index] : 1'b1;

  always_ff @(posedge clk)
  begin
    if (reset)
      tx_bit <= 1'b1;
    else if (state == st_hold_clk)
      tx_bit <= cmd_frame.start;
    else if ((state == st_send) && rise)
      tx_bit <= tx_next;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_reset:
        next_state = st_hold_clk;
      // the own pull-down restarts the watchdog, so the hold lasts one
      // watchdog period, a fall strobe still in flight means the done flag
      // is stale
      st_hold_clk:
        if (frame.watchdog_done && !clean_clk && !fall)
          next_state = st_send;
      st_send:
        if (rise && (frame.bit_count == last_tx_count))
          next_state = st_ack;
      // the device pulls data low for its eleventh clock pulse
      st_ack:
        if (fall)
          next_state = ps2_data_in ? st_error : st_await_reply;
      // the FA reply must follow inside one watchdog period so the count
      // reaches 22, the verify then fails and the bits are dropped
      st_await_reply:
        if (frame.bit_count == reply_count)
          next_state = st_verify;
      st_wait:
        if (fall)
          next_state = st_gather;
      // a short packet means a missed bit or a newly plugged mouse, so the
      // command goes out again
      st_gather:
        if (frame.watchdog_done)
        begin
          if (frame.bit_count == packet_count)
            next_state = st_verify;
          else
            next_state = st_hold_clk;
        end
      st_verify:
        next_state = st_wait;
      // only a reset leaves this state
      st_error:
        next_state = st_error;
      default:
        next_state = st_reset;
    endcase
  end

  // the report is stable in verify because no strobe can arrive while the
  // watchdog has just expired
  assign report_strobe  = (state == st_verify) && frame.packet_good;
  assign clk_drive_low  = (state == st_hold_clk);
  assign data_drive_low = (state == st_send) && !tx_bit;
  assign error_no_ack   = (state == st_error);

endmodule

// ==== tb/ps2_checker.sv ====
// ---------------------------------------------------------------------
// passive monitor for the PS/2 mouse front end, decodes the lines and
// compares cursor, buttons and error flag in each idle gap
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module ps2_checker #(
  parameter int idle_cycles = 400,
  parameter int max_x       = 300,
  parameter int max_y       = 200
) (
  input  logic        clk,
  input  logic        reset,
  input  wire         ps2_clk,
  input  wire         ps2_data,
  input  logic [11:0] mx,
  input  logic [11:0] my,
  input  logic [2:0]  btn_click,
  input  logic        error_no_ack,
  input  logic        ack_enabled,
  output int          error_count,
  output int          check_count
);

  logic [63:0] fall_bits;
  logic [63:0] rise_bits;
  int          fall_n;
  int          rise_n;
  int          idle;
  logic        active;
  logic        first_burst;
  logic        last_clk;
  logic        was_reset;
  int          model_x;
  int          model_y;
  logic [2:0]  model_btn;

  // moves one axis by a signed step and saturates at 0 and the limit
  function automatic int step_coord(input int pos, input int delta, input int limit);
    int next;
    next = pos + delta;
    if (next < 0)
      next = 0;
    else if (next > limit)
      next = limit;
    return next;
  endfunction

  // a frame is start low, eight data bits, odd parity and stop high
  function automatic logic frame_ok(input logic [10:0] f);
    return (f[0] == 1'b0) && (f[10] == 1'b1) && (^f[9:1] == 1'b1);
  endfunction

  // four-state compare so an unknown output never matches
  task automatic compare(input string what, input integer expected, input integer actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("ERR %0t: %s expected %0d actual %0d", $time, what, expected, actual);
    end
  endtask

  task automatic end_of_burst();
    logic [10:0] f0;
    logic [10:0] f1;
    logic [10:0] f2;
    int          dx;
    int          dy;
    if (first_burst)
    begin
      // the rise samples hold the start bit, then F4 from bit 0 up, then
      // the parity and the stop bit
      compare("command start", 0, rise_bits[0]);
      compare("command byte", 8'hf4, rise_bits[8:1]);
      compare("command parity", ~^rise_bits[8:1], rise_bits[9]);
      compare("command stop", 1, rise_bits[10]);
      first_burst = 1'b0;
    end
    else if (fall_n == 33)
    begin
      f0 = fall_bits[10:0];
      f1 = fall_bits[21:11];
      f2 = fall_bits[32:22];
      // only a clean packet on a link that was acknowledged moves the model
      if (ack_enabled && frame_ok(f0) && frame_ok(f1) && frame_ok(f2))
      begin
        dx = $signed({f0[5], f1[8:1]});
        dy = $signed({f0[6], f2[8:1]});
        model_x = step_coord(model_x, dx, max_x);
        // screen rows grow downward, so mouse-up is a negative step
        model_y = step_coord(model_y, -dy, max_y);
        model_btn = {f0[1], f0[3], f0[2]};
      end
    end
    else
    begin
      error_count++;
      $display("ERR %0t: burst of %0d bits is neither command nor packet", $time, fall_n);
    end
    compare("mx", model_x, mx);
    compare("my", model_y, my);
    compare("btn_click", model_btn, btn_click);
    compare("error_no_ack", !ack_enabled, error_no_ack);
  endtask

  initial
  begin
    error_count = 0;
    check_count = 0;
    last_clk    = 1'b1;
    was_reset   = 1'b0;
  end

  // ---------------------------------------------------------------------
  // PS/2 line decoder
  // ---------------------------------------------------------------------
  // edges are seen one clk late while the data line has settled long before
  always @(posedge clk)
  begin
    if (reset)
    begin
      fall_n      = 0;
      rise_n      = 0;
      idle        = 0;
      active      = 1'b0;
      first_burst = 1'b1;
      model_x     = 0;
      model_y     = 0;
      model_btn   = 3'b000;
      was_reset   = 1'b1;
    end
    else
    begin
      if (was_reset)
      begin
        compare("mx after reset", 0, mx);
        compare("my after reset", 0, my);
        compare("btn_click after reset", 0, btn_click);
        compare("error_no_ack after reset", 0, error_no_ack);
        was_reset = 1'b0;
      end
      if ((ps2_clk === 1'b0) && (last_clk === 1'b1))
      begin
        if (fall_n < 64)
          fall_bits[fall_n] = ps2_data;
        fall_n++;
        active = 1'b1;
        idle   = 0;
      end
      else if ((ps2_clk === 1'b1) && (last_clk === 1'b0))
      begin
        if (rise_n < 64)
          rise_bits[rise_n] = ps2_data;
        rise_n++;
        active = 1'b1;
        idle   = 0;
      end
      else if (active)
      begin
        idle++;
        if (idle == idle_cycles)
        begin
          end_of_burst();
          fall_n = 0;
          rise_n = 0;
          active = 1'b0;
        end
      end
    end
    last_clk = ps2_clk;
  end

endmodule

// ==== tb/tb_ps2_mouse_xy.sv ====
// ---------------------------------------------------------------------
// testbench for the PS/2 mouse front end, a behavioral mouse answers the
// enable command and sends good and corrupted movement packets
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module tb_ps2_mouse_xy;

  localparam int clk_period  = 40;
  localparam int wd_cycles   = 200;
  // a PS/2 bit is 10 setup, 20 low and 10 high clk cycles
  localparam int bit_cycles  = 40;
  localparam int byte_gap    = 40;
  localparam int packet_gap  = 3 * wd_cycles;
  localparam int num_packets = 20;
  localparam int packet_cycles = 3 * (11 * bit_cycles + byte_gap) + packet_gap;
  // two command sequences cost less than three packets
  localparam int limit_cycles = (num_packets + 6) * packet_cycles;

  logic clk;
  logic reset;
  logic mouse_clk_low;
  logic mouse_data_low;
  logic ack_enabled;
  wire  ps2_clk;
  wire  ps2_data;
  logic [11:0] mx;
  logic [11:0] my;
  logic [2:0]  btn_click;
  logic        error_no_ack;
  int          error_count;
  int          check_count;
  int unsigned seed_val;

  // open-drain bus, both sides only pull low
  pullup (ps2_clk);
  pullup (ps2_data);
  assign ps2_clk  = mouse_clk_low ? 1'b0 : 1'bz;
  assign ps2_data = mouse_data_low ? 1'b0 : 1'bz;

  always #(clk_period / 2) clk = ~clk;

  ps2_mouse_xy #(
    .watchdog_cycles(wd_cycles), .debounce_cycles(4), .max_x(300), .max_y(200)
  ) dut_i (
    .clk, .reset, .ps2_clk, .ps2_data, .mx, .my, .btn_click, .error_no_ack
  );

  ps2_checker #(.idle_cycles(2 * wd_cycles), .max_x(300), .max_y(200)) chk_i (
    .clk, .reset, .ps2_clk, .ps2_data, .mx, .my, .btn_click, .error_no_ack,
    .ack_enabled, .error_count, .check_count
  );

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one device clock pulse, low then high
  task automatic clock_pulse();
    mouse_clk_low = 1'b1;
    wait_cycles(20);
    mouse_clk_low = 1'b0;
    wait_cycles(10);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                            input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      mouse_data_low = !bits[i];
      wait_cycles(10);
      clock_pulse();
    end
    mouse_data_low = 1'b0;
  endtask

  // waits for the host request, clocks in ten bits and acknowledges or not
  task automatic take_command(input logic ack);
    while (ps2_clk !== 1'b0)
      @(negedge clk);
    while (ps2_clk !== 1'b1)
      @(negedge clk);
    wait_cycles(10);
    for (int i = 0; i < 10; i++)
    begin
      mouse_clk_low = 1'b1;
      wait_cycles(20);
      mouse_clk_low = 1'b0;
      wait_cycles(20);
    end
    mouse_data_low = ack;
    wait_cycles(10);
    clock_pulse();
    mouse_data_low = 1'b0;
    wait_cycles(byte_gap);
    if (ack)
      send_frame(8'hfa, 1'b0, 1'b0);
    wait_cycles(packet_gap);
  endtask

  // corrupt_frame picks a frame to spoil, -1 sends a clean packet
  task automatic send_packet(input logic [8:0] dx, input logic [8:0] dy,
                             input logic [2:0] lmr, input int corrupt_frame,
                             input logic stop_error);
    logic [7:0] bytes [3];
    bytes[0] = {2'b00, dy[8], dx[8], 1'b1, lmr[1], lmr[0], lmr[2]};
    bytes[1] = dx[7:0];
    bytes[2] = dy[7:0];
    for (int f = 0; f < 3; f++)
    begin
      send_frame(bytes[f], (f == corrupt_frame) && !stop_error,
                 (f == corrupt_frame) && stop_error);
      wait_cycles(byte_gap);
    end
    wait_cycles(packet_gap);
  endtask

  task automatic random_packet(input int corrupt_frame, input logic stop_error);
    send_packet(9'($urandom % 512), 9'($urandom % 512), 3'($urandom % 8),
                corrupt_frame, stop_error);
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    wait_cycles(8);
    reset = 1'b0;
  endtask

  initial
  begin
    clk            = 1'b0;
    reset          = 1'b1;
    mouse_clk_low  = 1'b0;
    mouse_data_low = 1'b0;
    ack_enabled    = 1'b1;
    seed_val       = $urandom(32'hf25d);
    @(negedge clk);
    apply_reset();
    take_command(1'b1);

    // mixed random movement
    for (int i = 0; i < 6; i++)
      random_packet(-1, 1'b0);
    // saturate toward max_x and y toward zero, then the other way
    for (int i = 0; i < 3; i++)
      send_packet(9'sd255, 9'sd255, 3'b101, -1, 1'b0);
    for (int i = 0; i < 3; i++)
      send_packet(-9'sd256, -9'sd256, 3'b010, -1, 1'b0);
    // spoiled packets must leave everything as it was
    random_packet(0, 1'b0);
    random_packet(1, 1'b0);
    random_packet(2, 1'b0);
    random_packet(1, 1'b1);
    for (int i = 0; i < 2; i++)
      random_packet(-1, 1'b0);

    // second run with the acknowledge withheld
    ack_enabled = 1'b0;
    apply_reset();
    take_command(1'b0);
    for (int i = 0; i < 2; i++)
      random_packet(-1, 1'b0);

    wait_cycles(10);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // run limit from the packet count and the worst-case packet length
  initial
  begin
    #(limit_cycles * clk_period);
    $display("run timed out before all packets were sent and checked");
    $display("TEST FAIL");
    $finish;
  end

endmodule
